// ==== source/fetch_align_pkg.sv ====
package fetch_align_pkg;

  // Address and data geometry.
  localparam int ADDR_BITS   = 32;  // Byte address.
  localparam int WORD_BITS   = 32;
  localparam int PARCEL_BITS = 16;  // One compressed instruction.

  // Line geometry.
  localparam int LINE_WORDS   = 4;
  localparam int LINE_PARCELS = 8;
  localparam int BANK_PARCELS = 4;  // Parcels per bank per line.

  // Cache geometry.
  localparam int NUM_SETS    = 8;
  localparam int OFFSET_BITS = 4;  // Byte offset within a line.
  localparam int INDEX_BITS  = 3;
  localparam int TAG_BITS    = 25;
  localparam int BEAT_BITS   = 2;  // Word within a line.

  // Refill sequence.
  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_ADDR,
    REFILL_DATA,
    REFILL_LOOKUP
  } refill_state_e;

  // One 32-bit word, seen whole or as two parcels.
  typedef union packed {
    logic [WORD_BITS-1:0] word;
    struct packed {
      logic [PARCEL_BITS-1:0] hi;  // Odd parcel.
      logic [PARCEL_BITS-1:0] lo;  // Even parcel.
    } parcels;
  } fill_word_u;

  // Byte address without its line offset.
  typedef logic [ADDR_BITS-OFFSET_BITS-1:0] line_addr_t;

endpackage

// ==== source/line_fill_if.sv ====
`timescale 1ns/1ps

interface line_fill_if
  import fetch_align_pkg::*;
();

  // Store to refill.
  logic       miss_o;  // Held request misses.
  line_addr_t miss_line_o;
  logic       busy_o;  // A request is held.

  // Refill to store.
  logic                  fill_we;
  logic [INDEX_BITS-1:0] fill_idx;
  logic [BEAT_BITS-1:0]  fill_beat;
  fill_word_u            fill_word;
  logic                  fill_tag_we;  // With the last beat.
  logic [TAG_BITS-1:0]   fill_tag;
  logic                  relookup;

  modport store (
    output miss_o, miss_line_o, busy_o,
    input  fill_we, fill_idx, fill_beat, fill_word, fill_tag_we, fill_tag, relookup
  );

  modport refill (
    input  miss_o, miss_line_o, busy_o,
    output fill_we, fill_idx, fill_beat, fill_word, fill_tag_we, fill_tag, relookup
  );

endinterface

// ==== source/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter
  import fetch_align_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clear_i,    // Refill start.
  input  logic                 advance_i,  // R beat accepted.
  output logic [BEAT_BITS-1:0] beat_o,
  output logic                 last_beat_o
);

  logic [BEAT_BITS-1:0] beat_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_q <= '0;
    end else if (clear_i) begin
      beat_q <= '0;
    end else if (advance_i) begin
      beat_q <= beat_q + 1'b1;  // Wraps after the last word.
    end
  end

  assign beat_o = beat_q;

  // High on the edge that takes the final word of the line.
  assign last_beat_o = advance_i && (beat_q == BEAT_BITS'(LINE_WORDS - 1));

endmodule

// ==== source/refill_fsm.sv ====
`timescale 1ns/1ps

module refill_fsm
  import fetch_align_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  output logic [ADDR_BITS-1:0] araddr_o,
  output logic                 arvalid_o,
  input  logic                 arready_i,
  input  logic [WORD_BITS-1:0] rdata_i,
  input  logic                 rvalid_i,
  output logic                 rready_o,
  input  logic [BEAT_BITS-1:0] beat_i,
  input  logic                 last_beat_i,
  output logic                 beat_clear_o,
  output logic                 beat_advance_o,
  line_fill_if.refill          fill
);

  refill_state_e state_q;
  refill_state_e state_d;
  line_addr_t    line_q;  // Line being fetched.
  logic          start;
  logic          beat_done;

  assign start     = (state_q == REFILL_IDLE) && fill.miss_o;
  assign beat_done = rready_o && rvalid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      REFILL_IDLE:   if (fill.miss_o) state_d = REFILL_ADDR;
      REFILL_ADDR:   if (arready_i) state_d = REFILL_DATA;
      REFILL_DATA: begin
        if (rvalid_i) state_d = last_beat_i ? REFILL_LOOKUP : REFILL_ADDR;
      end
      REFILL_LOOKUP: state_d = REFILL_IDLE;
      default:       state_d = REFILL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_q <= REFILL_IDLE;
    else state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (start) line_q <= fill.miss_line_o;
  end

  // AXI4-Lite read channels.
  assign arvalid_o = (state_q == REFILL_ADDR);
  assign rready_o  = (state_q == REFILL_DATA);
  assign araddr_o  = {line_q, beat_i, {(OFFSET_BITS - BEAT_BITS){1'b0}}};  // Word aligned.

  assign beat_clear_o   = start;
  assign beat_advance_o = beat_done;

  // Fill writes, one per accepted beat.
  assign fill.fill_we     = beat_done;
  assign fill.fill_idx    = line_q[INDEX_BITS-1:0];
  assign fill.fill_beat   = beat_i;
  assign fill.fill_word   = rdata_i;
  assign fill.fill_tag_we = beat_done && last_beat_i;
  assign fill.fill_tag    = line_q[ADDR_BITS-OFFSET_BITS-1:INDEX_BITS];
  assign fill.relookup    = (state_q == REFILL_LOOKUP);

  a_ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)));

  // The request stays held for the whole refill.
  a_busy_in_refill: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q != REFILL_IDLE) |-> fill.busy_o);

endmodule

// ==== source/parcel_bank_store.sv ====
`timescale 1ns/1ps

module parcel_bank_store
  import fetch_align_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 flush_i,
  input  logic                 req_valid_i,
  input  logic [ADDR_BITS-1:0] req_addr_i,
  output logic                 req_ready_o,
  output logic                 rsp_valid_o,
  output logic [WORD_BITS-1:0] rsp_instr_o,
  output logic                 rsp_compressed_o,
  input  logic                 rsp_ready_i,
  line_fill_if.store           fill
);

  // Even parcels in one bank, odd parcels in the other.
  logic [PARCEL_BITS-1:0] even_bank [NUM_SETS][BANK_PARCELS];
  logic [PARCEL_BITS-1:0] odd_bank  [NUM_SETS][BANK_PARCELS];
  logic [TAG_BITS-1:0]    tag_mem   [NUM_SETS];
  logic [NUM_SETS-1:0]    valid_q;

  logic                 held_q;  // Request held.
  logic                 look_q;  // Lookup this cycle.
  logic                 miss_q;
  logic [ADDR_BITS-1:0] req_addr_q;
  line_addr_t           miss_line_q;

  line_addr_t             line0;
  line_addr_t             line1;  // Line after line0.
  logic [INDEX_BITS-1:0]  idx0;
  logic [INDEX_BITS-1:0]  idx1;
  logic [OFFSET_BITS-2:0] parcel_idx;
  logic [BEAT_BITS-1:0]   odd_slot;
  logic [BEAT_BITS-1:0]   even_slot;
  logic [INDEX_BITS-1:0]  even_idx;
  logic [PARCEL_BITS-1:0] even_parcel;
  logic [PARCEL_BITS-1:0] odd_parcel;
  logic                   need_next;  // Window crosses into line1.
  logic                   hit0;
  logic                   hit1;
  logic                   hit;
  logic                   accept;
  fill_word_u             window;

  assign req_ready_o = !held_q;
  assign accept      = req_valid_i && req_ready_o;

  // Decode of the held address.
  assign line0      = req_addr_q[ADDR_BITS-1:OFFSET_BITS];
  assign line1      = line0 + 1'b1;  // Tag carries on set wrap.
  assign idx0       = line0[INDEX_BITS-1:0];
  assign idx1       = line1[INDEX_BITS-1:0];
  assign parcel_idx = req_addr_q[OFFSET_BITS-1:1];
  assign need_next  = (parcel_idx == (OFFSET_BITS-1)'(LINE_PARCELS - 1));

  // Odd bank always reads from line0. Even bank steps a slot for odd p.
  assign odd_slot  = parcel_idx[OFFSET_BITS-2:1];
  assign even_slot = odd_slot + BEAT_BITS'(parcel_idx[0]);
  assign even_idx  = need_next ? idx1 : idx0;

  assign even_parcel = even_bank[even_idx][even_slot];
  assign odd_parcel  = odd_bank[idx0][odd_slot];

  always_comb begin
    if (parcel_idx[0]) begin
      window.parcels.lo = odd_parcel;
      window.parcels.hi = even_parcel;
    end else begin
      window.parcels.lo = even_parcel;
      window.parcels.hi = odd_parcel;
    end
  end

  // Tag check on both candidate lines.
  assign hit0 = valid_q[idx0] && (tag_mem[idx0] == line0[ADDR_BITS-OFFSET_BITS-1:INDEX_BITS]);
  assign hit1 = valid_q[idx1] && (tag_mem[idx1] == line1[ADDR_BITS-OFFSET_BITS-1:INDEX_BITS]);
  assign hit  = look_q && hit0 && (!need_next || hit1);

  assign fill.miss_o      = miss_q;
  assign fill.miss_line_o = miss_line_q;
  assign fill.busy_o      = held_q;

  // Bank and tag writes.
  always_ff @(posedge clk_i) begin
    if (fill.fill_we) begin
      even_bank[fill.fill_idx][fill.fill_beat] <= fill.fill_word.parcels.lo;
      odd_bank[fill.fill_idx][fill.fill_beat]  <= fill.fill_word.parcels.hi;
    end
    if (fill.fill_tag_we) tag_mem[fill.fill_idx] <= fill.fill_tag;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      if (flush_i) valid_q <= '0;
      if (fill.fill_tag_we) valid_q[fill.fill_idx] <= 1'b1;  // Refill in flight still lands.
    end
  end

  // Request control.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      held_q      <= 1'b0;
      look_q      <= 1'b0;
      miss_q      <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      if (accept) begin
        held_q <= 1'b1;
        look_q <= 1'b1;
      end
      if (look_q) begin
        look_q <= 1'b0;
        if (hit) rsp_valid_o <= 1'b1;
        else miss_q <= 1'b1;
      end
      if (fill.relookup) begin
        miss_q <= 1'b0;
        look_q <= 1'b1;  // Check again next cycle.
      end
      if (rsp_valid_o && rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
        held_q      <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) req_addr_q <= req_addr_i;
    if (look_q && !hit) miss_line_q <= hit0 ? line1 : line0;  // Missing line0 goes first.
    if (hit) begin
      rsp_instr_o      <= window.word;
      rsp_compressed_o <= (window.word[1:0] != 2'b11);
    end
  end

  a_req_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |-> !req_addr_i[0]);

  // Response holds under back-pressure.
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (rsp_valid_o && !rsp_ready_i) |=>
      (rsp_valid_o && $stable(rsp_instr_o) && $stable(rsp_compressed_o)));

endmodule

// ==== source/fetch_align.sv ====
`timescale 1ns/1ps

module fetch_align
  import fetch_align_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 flush_i,
  // Fetch request.
  input  logic                 req_valid_i,
  input  logic [ADDR_BITS-1:0] req_addr_i,
  output logic                 req_ready_o,
  // Fetch response.
  output logic                 rsp_valid_o,
  output logic [WORD_BITS-1:0] rsp_instr_o,
  output logic                 rsp_compressed_o,
  input  logic                 rsp_ready_i,
  // AXI4-Lite read address channel.
  output logic [ADDR_BITS-1:0] araddr_o,
  output logic                 arvalid_o,
  input  logic                 arready_i,
  // AXI4-Lite read data channel.
  input  logic [WORD_BITS-1:0] rdata_i,
  input  logic                 rvalid_i,
  output logic                 rready_o
);

  logic [BEAT_BITS-1:0] beat;
  logic                 last_beat;
  logic                 beat_clear;
  logic                 beat_advance;

  line_fill_if u_line_fill ();

  parcel_bank_store u_parcel_bank_store (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flush_i         (flush_i),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_instr_o     (rsp_instr_o),
    .rsp_compressed_o(rsp_compressed_o),
    .rsp_ready_i     (rsp_ready_i),
    .fill            (u_line_fill.store)
  );

  refill_fsm u_refill_fsm (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .arready_i     (arready_i),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i),
    .rready_o      (rready_o),
    .beat_i        (beat),
    .last_beat_i   (last_beat),
    .beat_clear_o  (beat_clear),
    .beat_advance_o(beat_advance),
    .fill          (u_line_fill.refill)
  );

  beat_counter u_beat_counter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .clear_i    (beat_clear),
    .advance_i  (beat_advance),
    .beat_o     (beat),
    .last_beat_o(last_beat)
  );

endmodule

// ==== testbench/tb_axi_lite_mem.sv ====
`timescale 1ns/1ps

module tb_axi_lite_mem (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic        ar_stall_i,  // Wait state request for AR.
  input  logic        r_stall_i    // Wait state request for R.
);

  logic [31:0] image [256];  // 1 KiB image where higher addresses wrap.
  logic        pending_q;    // AR taken, R not yet.
  logic [31:0] addr_q;
  logic        ar_stall_q;
  logic        r_stall_q;

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
  end

  // Handshakes and stall bits are sampled on the rising edge.
  always @(posedge clk_i) begin
    ar_stall_q <= ar_stall_i;
    r_stall_q  <= r_stall_i;
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (arvalid_i && arready_o) begin
      pending_q <= 1'b1;
      addr_q    <= araddr_i;
    end else if (rvalid_o && rready_i) begin
      pending_q <= 1'b0;
    end
  end

  // Outputs change on the falling edge.
  always @(negedge clk_i) begin
    arready_o = !reset_i && !pending_q && arvalid_i && !ar_stall_q;
    rvalid_o  = !reset_i && pending_q && !r_stall_q;
    rdata_o   = image[addr_q[9:2]];  // Word index.
  end

endmodule

// ==== testbench/tb_fetch_align.sv ====
`timescale 1ns/1ps

module tb_fetch_align
  import fetch_align_pkg::*;
();

  localparam int WAIT_LIMIT = 400;  // Cycles per wait.

  logic                 clk_i;
  logic                 reset_i;
  logic                 flush_i;
  logic                 req_valid_i;
  logic [ADDR_BITS-1:0] req_addr_i;
  logic                 req_ready_o;
  logic                 rsp_valid_o;
  logic [WORD_BITS-1:0] rsp_instr_o;
  logic                 rsp_compressed_o;
  logic                 rsp_ready_i;
  logic [ADDR_BITS-1:0] araddr_o;
  logic                 arvalid_o;
  logic                 arready_i;
  logic [WORD_BITS-1:0] rdata_i;
  logic                 rvalid_i;
  logic                 rready_o;
  logic                 ar_stall;
  logic                 r_stall;

  logic [31:0]          lfsr_q;
  int                   pass_count;
  int                   fail_count;
  int                   fails_before;
  bit                   timed_out;
  logic [ADDR_BITS-1:0] test_addr;
  logic [ADDR_BITS-1:0] ar_seen [$];
  logic [ADDR_BITS-1:0] ar_expect [$];
  line_addr_t           shadow_line [NUM_SETS];  // Model of the tag store.
  logic [NUM_SETS-1:0]  shadow_valid;

  fetch_align u_fetch_align (.*);

  tb_axi_lite_mem u_mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .araddr_i  (araddr_o),
    .arvalid_i (arvalid_o),
    .arready_o (arready_i),
    .rdata_o   (rdata_i),
    .rvalid_o  (rvalid_i),
    .rready_i  (rready_o),
    .ar_stall_i(ar_stall),
    .r_stall_i (r_stall)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (!reset_i && arvalid_o && arready_i) ar_seen.push_back(araddr_o);
  end

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [PARCEL_BITS-1:0] parcel_at(input logic [ADDR_BITS-1:0] addr);
    logic [WORD_BITS-1:0] w;
    w = u_mem.image[addr[9:2]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic line_cached(input line_addr_t line);
    return shadow_valid[line[INDEX_BITS-1:0]] && (shadow_line[line[INDEX_BITS-1:0]] == line);
  endfunction

  task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                       input string what);
    if (expected === actual) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("CHECK FAILED at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic report_timeout(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    timed_out = 1'b1;
    fail_count++;
  endtask

  // Every clock step goes through here and draws fresh AXI wait states.
  task automatic next_cycle();
    @(negedge clk_i);
    ar_stall = (rand_bits(1) == 0);
    r_stall  = (rand_bits(1) == 0);
  endtask

  task automatic wait_req_ready();
    int n;
    n = 0;
    while (!req_ready_o && !timed_out) begin
      if (n == WAIT_LIMIT) begin
        report_timeout("timed out waiting for req_ready_o to rise");
      end else begin
        next_cycle();
        n++;
      end
    end
  endtask

  task automatic expect_refill(input line_addr_t line);
    for (int b = 0; b < LINE_WORDS; b++) ar_expect.push_back({line, OFFSET_BITS'(4 * b)});
    shadow_line[line[INDEX_BITS-1:0]]  = line;
    shadow_valid[line[INDEX_BITS-1:0]] = 1'b1;
  endtask

  task automatic flush_cache();
    wait_req_ready();
    if (timed_out) return;
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    shadow_valid = '0;
  endtask

  task automatic fetch(input logic [ADDR_BITS-1:0] addr);
    line_addr_t           line0;
    logic                 crosses;
    logic                 hit;
    logic [WORD_BITS-1:0] expected;
    int                   lat;
    int                   stalls;
    line0    = addr[ADDR_BITS-1:OFFSET_BITS];
    crosses  = (addr[3:1] == 3'd7);
    hit      = line_cached(line0) && (!crosses || line_cached(line0 + 1'b1));
    expected = {parcel_at(addr + 2), parcel_at(addr)};
    ar_expect.delete();
    if (!line_cached(line0)) expect_refill(line0);  // First parcel's line goes first.
    if (crosses && !line_cached(line0 + 1'b1)) expect_refill(line0 + 1'b1);
    wait_req_ready();
    if (timed_out) return;
    ar_seen.delete();
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    next_cycle();
    req_valid_i = 1'b0;
    check(0, req_ready_o, "req_ready_o low while held");
    lat = 0;
    while (!rsp_valid_o && !timed_out) begin
      if (lat == WAIT_LIMIT) begin
        report_timeout("timed out waiting for rsp_valid_o");
      end else begin
        next_cycle();
        lat++;
      end
    end
    if (timed_out) return;
    if (hit) check(1, lat, "hit latency");
    check(expected, rsp_instr_o, "window");
    check(expected[1:0] != 2'b11, rsp_compressed_o, "compressed flag");
    stalls = rand_bits(2);
    for (int i = 0; i < stalls; i++) begin
      next_cycle();
      check(1, rsp_valid_o, "rsp_valid_o held under back-pressure");
      check(expected, rsp_instr_o, "window held");
      check(expected[1:0] != 2'b11, rsp_compressed_o, "compressed flag held");
      check(0, req_ready_o, "req_ready_o low under back-pressure");
    end
    rsp_ready_i = 1'b1;
    next_cycle();
    rsp_ready_i = 1'b0;
    check(0, rsp_valid_o, "rsp_valid_o after accept");
    check(ar_expect.size(), ar_seen.size(), "AR transfer count");
    foreach (ar_expect[i]) begin
      if (i < ar_seen.size()) check(ar_expect[i], ar_seen[i], "AR address");
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished, %0d failed checks", name, fail_count - fails_before);
    fails_before = fail_count;
  endtask

  initial begin
    lfsr_q       = 32'h1f059b08;
    pass_count   = 0;
    fail_count   = 0;
    fails_before = 0;
    timed_out    = 1'b0;
    shadow_valid = '0;
    reset_i      = 1'b1;
    flush_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    rsp_ready_i  = 1'b0;
    ar_stall     = 1'b0;
    r_stall      = 1'b0;
    for (int k = 0; k < 256; k++) u_mem.image[k] = rand_bits(32);
    for (int i = 0; i < 3; i++) next_cycle();
    reset_i = 1'b0;
    check(1, req_ready_o, "req_ready_o after reset");
    check(0, rsp_valid_o, "rsp_valid_o after reset");
    check(0, arvalid_o, "arvalid_o after reset");
    check(0, rready_o, "rready_o after reset");
    report_test("reset");

    for (int n = 0; n < 200; n++) fetch(rand_bits(9) << 1);
    report_test("random windows");

    // Set 7 to set 0 wrap with none, both and one line cached.
    flush_cache();
    fetch(32'h7e);
    fetch(32'h7e);
    flush_cache();
    fetch(32'h80);
    fetch(32'h7e);
    flush_cache();
    fetch(32'h70);
    fetch(32'h7e);
    for (int n = 0; n < 16; n++) fetch((rand_bits(6) << 4) | 32'he);
    report_test("line crossing");

    test_addr = rand_bits(9) << 1;
    fetch(test_addr);
    fetch(test_addr);
    flush_cache();
    fetch(test_addr);
    check(1, ar_seen.size() >= LINE_WORDS, "refill after flush");
    report_test("flush refetch");

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== fetch_align.f ====
source/fetch_align_pkg.sv
source/line_fill_if.sv
source/beat_counter.sv
source/refill_fsm.sv
source/parcel_bank_store.sv
source/fetch_align.sv
testbench/tb_axi_lite_mem.sv
testbench/tb_fetch_align.sv

// ==== Bender.yml ====
package:
  name: fetch_align

dependencies: {}

sources:
  # Design, in compile order.
  - files:
      - source/fetch_align_pkg.sv
      - source/line_fill_if.sv
      - source/beat_counter.sv
      - source/refill_fsm.sv
      - source/parcel_bank_store.sv
      - source/fetch_align.sv

  # Testbench.
  - target: test
    files:
      - testbench/tb_axi_lite_mem.sv
      - testbench/tb_fetch_align.sv
